// ==== mant_div_pkg.sv ====
// width typedefs and fixed constants of the 53-bit mantissa divider
`default_nettype none

package mant_div_pkg;

    // double-precision mantissa incl. hidden bit
    typedef logic [52:0] mant_t;

    // raw quotient, eight 8-bit groups
    typedef logic [63:0] quot_t;

    typedef logic [5:0] lzc_t;          // leading zeros of an operand, 0..52

    // bit position inside quot_t, same width as the divstage53 index fields
    typedef logic [6:0] qpos_t;

    typedef logic signed [7:0] expadj_t;    // exponent correction

    typedef logic [2:0] step_t;         // core step counter

    localparam int DIV_STEPS = 8;       // radix-256 iterations
    localparam int QUOT_TOP  = 56;      // integer bit of the first step

endpackage

`default_nettype wire

// ==== divstage53.sv ====
// divstage53: radix-256 division step with leading-one index select
`timescale 1ns/1ns
`default_nettype none

module divstage53 (
    input  wire logic                i_mux_ena,     // search for first nonzero bit
    input  wire logic [55:0]         i_muxind,      // 8 x 7-bit bit positions
    input  wire logic [60:0]         i_divident,
    input  wire mant_div_pkg::mant_t i_divisor,
    output mant_div_pkg::mant_t      o_dif,         // remainder
    output logic [7:0]               o_bits,        // quotient bits of this step
    output mant_div_pkg::qpos_t      o_muxind,      // position of highest set bit
    output logic                     o_muxind_rdy
);

    always_comb begin
        logic [54:0] divx2;
        logic [54:0] divx3;
        logic [60:0] part;      // partial remainder between radix-4 steps
        logic [61:0] diff3;
        logic [61:0] diff2;
        logic [61:0] diff1;
        logic [7:0]  bits;
        logic [2:0]  top;

        divx2 = {1'b0, i_divisor, 1'b0};
        divx3 = divx2 + {2'b00, i_divisor};
        part  = i_divident;
        bits  = '0;

        // four radix-4 digits, msb pair first
        for (int k = 3; k >= 0; k--) begin
            diff3 = {1'b0, part} - ({7'd0, divx3} << (2 * k));
            diff2 = {1'b0, part} - ({7'd0, divx2} << (2 * k));
            diff1 = {1'b0, part} - ({9'd0, i_divisor} << (2 * k));

            // sign bit clear means the trial subtraction fits
            if (!diff3[61]) begin
                bits[2*k +: 2] = 2'd3;
                part = diff3[60:0];
            end else if (!diff2[61]) begin
                bits[2*k +: 2] = 2'd2;
                part = diff2[60:0];
            end else if (!diff1[61]) begin
                bits[2*k +: 2] = 2'd1;
                part = diff1[60:0];
            end else begin
                bits[2*k +: 2] = 2'd0;
            end
        end

        // highest set quotient bit picks its index field
        top = '0;
        for (int i = 0; i < 8; i++) begin
            if (bits[i]) begin
                top = 3'(i);
            end
        end

        o_bits       = bits;
        o_dif        = part[52:0];                  // remainder < divisor
        o_muxind     = i_mux_ena ? i_muxind[7*top +: 7] : '0;
        o_muxind_rdy = i_mux_ena & (|bits);
    end

endmodule

`default_nettype wire

// ==== mant_div_prenorm.sv ====
// mant_div_prenorm: leading-zero count and left alignment of both operands
`timescale 1ns/1ns
`default_nettype none

module mant_div_prenorm (
    input  wire logic                i_clk,
    input  wire logic                i_reset,
    input  wire logic                i_ena,
    input  wire logic                i_busy,        // core still occupied
    input  wire mant_div_pkg::mant_t i_divident,
    input  wire mant_div_pkg::mant_t i_divisor,
    output logic                     o_valid,
    output mant_div_pkg::mant_t      o_a,
    output mant_div_pkg::mant_t      o_b,
    output mant_div_pkg::lzc_t       o_lzc_a,
    output mant_div_pkg::lzc_t       o_lzc_b
);
    import mant_div_pkg::*;

    // priority count, highest set bit wins
    function automatic lzc_t lead_zeros(input mant_t v);
        lzc_t cnt;
        cnt = '0;
        for (int i = 0; i < $bits(mant_t); i++) begin
            if (v[i]) begin
                cnt = lzc_t'($bits(mant_t) - 1 - i);
            end
        end
        return cnt;
    endfunction

    lzc_t lzc_a;
    lzc_t lzc_b;
    logic accept;

    assign lzc_a  = lead_zeros(i_divident);
    assign lzc_b  = lead_zeros(i_divisor);
    assign accept = i_ena & ~i_busy;    // strobes during busy are dropped

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= accept;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_a     <= i_divident << lzc_a;     // bit 52 now set
            o_b     <= i_divisor << lzc_b;
            o_lzc_a <= lzc_a;
            o_lzc_b <= lzc_b;
        end
    end

endmodule

`default_nettype wire

// ==== mant_div_core.sv ====
// mant_div_core: eight-step radix-256 divide loop around divstage53
`timescale 1ns/1ns
`default_nettype none

module mant_div_core (
    input  wire logic                i_clk,
    input  wire logic                i_reset,
    input  wire logic                i_start,
    input  wire mant_div_pkg::mant_t i_a,
    input  wire mant_div_pkg::mant_t i_b,
    input  wire mant_div_pkg::lzc_t  i_lzc_a,
    input  wire mant_div_pkg::lzc_t  i_lzc_b,
    output logic                     o_busy,
    output logic                     o_done,
    output mant_div_pkg::quot_t      o_quot,
    output mant_div_pkg::qpos_t      o_pos,
    output logic                     o_rem_nz,
    output mant_div_pkg::lzc_t       o_lzc_a,
    output mant_div_pkg::lzc_t       o_lzc_b
);
    import mant_div_pkg::*;

    typedef enum logic {IDLE, RUN} core_state_t;

    core_state_t state_q;
    step_t       step_q;
    logic        search_q;      // leading one not found yet
    logic        done_q;
    mant_t       rem_q;         // holds A' at load, remainder afterwards
    mant_t       div_q;
    quot_t       quot_q;
    qpos_t       pos_q;
    lzc_t        lzc_a_q;
    lzc_t        lzc_b_q;

    logic [60:0] stage_divident;
    logic [55:0] stage_muxind;
    mant_t       stage_dif;
    logic [7:0]  stage_bits;
    qpos_t       stage_pos;
    logic        stage_rdy;

    assign stage_divident = (step_q == '0) ? {8'd0, rem_q} : {rem_q, 8'd0};

    // field i gets the quotient position of bit i in this step
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            stage_muxind[7*i +: 7] = qpos_t'(QUOT_TOP - 8 * int'(step_q) + i);
        end
    end

    divstage53 u_stage (
        .i_mux_ena    (search_q),
        .i_muxind     (stage_muxind),
        .i_divident   (stage_divident),
        .i_divisor    (div_q),
        .o_dif        (stage_dif),
        .o_bits       (stage_bits),
        .o_muxind     (stage_pos),
        .o_muxind_rdy (stage_rdy)
    );

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q  <= IDLE;
            step_q   <= '0;
            search_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (i_start) begin
                        state_q  <= RUN;
                        step_q   <= '0;
                        search_q <= 1'b1;
                    end
                end
                RUN: begin
                    step_q <= step_q + step_t'(1);     // wraps to 0 after last step
                    if (stage_rdy) begin
                        search_q <= 1'b0;
                    end
                    if (step_q == step_t'(DIV_STEPS - 1)) begin
                        state_q <= IDLE;
                        done_q  <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == IDLE && i_start) begin
            rem_q   <= i_a;
            div_q   <= i_b;
            lzc_a_q <= i_lzc_a;
            lzc_b_q <= i_lzc_b;
        end else if (state_q == RUN) begin
            rem_q  <= stage_dif;
            quot_q <= {quot_q[55:0], stage_bits};   // 8 new bits per step
            if (stage_rdy) begin
                pos_q <= stage_pos;                 // first leading one only
            end
        end
    end

    assign o_busy   = i_start | (state_q == RUN);
    assign o_done   = done_q;
    assign o_quot   = quot_q;
    assign o_pos    = pos_q;
    assign o_rem_nz = |rem_q;
    assign o_lzc_a  = lzc_a_q;
    assign o_lzc_b  = lzc_b_q;

endmodule

`default_nettype wire

// ==== mant_div_postnorm.sv ====
// mant_div_postnorm: quotient alignment, sticky bit and exponent correction
`timescale 1ns/1ns
`default_nettype none

module mant_div_postnorm (
    input  wire logic                i_clk,
    input  wire logic                i_reset,
    input  wire logic                i_valid,
    input  wire mant_div_pkg::quot_t i_quot,
    input  wire mant_div_pkg::qpos_t i_pos,        // leading one, 55 or 56
    input  wire logic                i_rem_nz,
    input  wire mant_div_pkg::lzc_t  i_lzc_a,
    input  wire mant_div_pkg::lzc_t  i_lzc_b,
    output logic                     o_valid,
    output mant_div_pkg::mant_t      o_mant,
    output mant_div_pkg::expadj_t    o_exp_adj,
    output logic                     o_sticky
);
    import mant_div_pkg::*;

    localparam int MANT_MSB = $bits(mant_t) - 1;

    qpos_t   shift;
    quot_t   low_mask;
    mant_t   mant;
    logic    sticky;
    expadj_t exp_adj;

    assign shift    = i_pos - qpos_t'(MANT_MSB);      // bits dropped below mantissa
    assign low_mask = (quot_t'(1) << shift) - quot_t'(1);
    assign mant     = mant_t'(i_quot >> shift);
    assign sticky   = (|(i_quot & low_mask)) | i_rem_nz;

    // lzc_b - lzc_a - (56 - pos)
    assign exp_adj = expadj_t'(int'(i_lzc_b) - int'(i_lzc_a) - (QUOT_TOP - int'(i_pos)));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_mant    <= mant;
            o_exp_adj <= exp_adj;
            o_sticky  <= sticky;
        end
    end

endmodule

`default_nettype wire

// ==== mant_div53.sv ====
// mant_div53: top level chaining prenorm, core and postnorm stages
`timescale 1ns/1ns
`default_nettype none

module mant_div53 (
    input  wire logic                i_clk,
    input  wire logic                i_reset,
    input  wire logic                i_ena,         // start strobe
    input  wire mant_div_pkg::mant_t i_divident,
    input  wire mant_div_pkg::mant_t i_divisor,
    output logic                     o_busy,
    output logic                     o_valid,       // result strobe
    output mant_div_pkg::mant_t      o_mant,
    output mant_div_pkg::expadj_t    o_exp_adj,
    output logic                     o_sticky
);
    import mant_div_pkg::*;

    // prenorm to core
    logic  norm_valid;
    mant_t norm_a;
    mant_t norm_b;
    lzc_t  lzc_a;
    lzc_t  lzc_b;

    // core to postnorm
    logic  core_done;
    quot_t core_quot;
    qpos_t core_pos;
    logic  core_rem_nz;
    lzc_t  core_lzc_a;
    lzc_t  core_lzc_b;

    mant_div_prenorm u_prenorm (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_ena      (i_ena),
        .i_busy     (o_busy),
        .i_divident (i_divident),
        .i_divisor  (i_divisor),
        .o_valid    (norm_valid),
        .o_a        (norm_a),
        .o_b        (norm_b),
        .o_lzc_a    (lzc_a),
        .o_lzc_b    (lzc_b)
    );

    mant_div_core u_core (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_start  (norm_valid),
        .i_a      (norm_a),
        .i_b      (norm_b),
        .i_lzc_a  (lzc_a),
        .i_lzc_b  (lzc_b),
        .o_busy   (o_busy),
        .o_done   (core_done),
        .o_quot   (core_quot),
        .o_pos    (core_pos),
        .o_rem_nz (core_rem_nz),
        .o_lzc_a  (core_lzc_a),
        .o_lzc_b  (core_lzc_b)
    );

    mant_div_postnorm u_postnorm (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_valid   (core_done),
        .i_quot    (core_quot),
        .i_pos     (core_pos),
        .i_rem_nz  (core_rem_nz),
        .i_lzc_a   (core_lzc_a),
        .i_lzc_b   (core_lzc_b),
        .o_valid   (o_valid),
        .o_mant    (o_mant),
        .o_exp_adj (o_exp_adj),
        .o_sticky  (o_sticky)
    );

endmodule

`default_nettype wire

// ==== tb_mant_div53.sv ====
// testbench for mant_div53: vector-file stimulus, result, latency and busy-window checks
`timescale 1ns/1ns
`default_nettype none

module tb_mant_div53;
    import mant_div_pkg::*;

    localparam int MAX_VEC = 32;
    localparam int LATENCY = 11;        // accepting edge to o_valid

    logic    i_clk = 1'b0;
    logic    i_reset;
    logic    i_ena;
    mant_t   i_divident;
    mant_t   i_divisor;
    logic    o_busy;
    logic    o_valid;
    mant_t   o_mant;
    expadj_t o_exp_adj;
    logic    o_sticky;

    mant_t vec_mem [0:5*MAX_VEC-1];     // a, b, mant, exp_adj, sticky per vector
    int    num_vec;
    int    seed;
    int    gap;
    int    cyc;
    int    cur_idx;                     // vector on the inputs, -1 for junk strobes
    int    last_acc;
    logic  started;
    int    n_starts;
    int    n_results;
    int    idx_q [$];
    int    due_q [$];                   // cycle at which each result is due
    logic  exp_busy;
    logic  exp_valid;
    int    res_idx;

    mant_div53 dut0 (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_ena      (i_ena),
        .i_divident (i_divident),
        .i_divisor  (i_divisor),
        .o_busy     (o_busy),
        .o_valid    (o_valid),
        .o_mant     (o_mant),
        .o_exp_adj  (o_exp_adj),
        .o_sticky   (o_sticky)
    );

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h (cycle %0d)",
                                name, got, exp, cyc));
        end
    endtask

    // hold the start strobe high until the dut takes it
    task automatic start_op(input int idx);
        @(posedge i_clk);
        cur_idx = idx;
        i_ena      <= 1'b1;
        i_divident <= vec_mem[5*idx];
        i_divisor  <= vec_mem[5*idx+1];
        do begin
            @(negedge i_clk);
        end while (o_busy);
        @(posedge i_clk);
        i_ena   <= 1'b0;
        cur_idx = -1;
    endtask

    // one junk strobe well inside the busy window
    task automatic pulse_during_busy();
        repeat (3) @(posedge i_clk);
        i_ena      <= 1'b1;
        i_divident <= mant_t'($random(seed));
        i_divisor  <= mant_t'($random(seed));
        @(posedge i_clk);
        i_ena <= 1'b0;
    endtask

    // outputs sampled mid-cycle, where they are stable
    always @(negedge i_clk) begin
        if (i_reset) begin
            if (cyc > 0) begin
                check_value("o_valid", 64'(o_valid), 64'd0);
                check_value("o_busy", 64'(o_busy), 64'd0);
            end
        end else begin
            exp_busy  = started && (cyc >= last_acc + 1) && (cyc <= last_acc + 9);
            exp_valid = (due_q.size() > 0) && (due_q[0] == cyc);
            check_value("o_busy", 64'(o_busy), 64'(exp_busy));
            check_value("o_valid", 64'(o_valid), 64'(exp_valid));
            if (o_valid) begin
                res_idx = idx_q.pop_front();
                void'(due_q.pop_front());
                check_value("o_mant", 64'(o_mant), 64'(vec_mem[5*res_idx+2]));
                check_value("o_exp_adj", 64'($unsigned(o_exp_adj)),
                            64'(vec_mem[5*res_idx+3][7:0]));
                check_value("o_sticky", 64'(o_sticky), 64'(vec_mem[5*res_idx+4][0]));
                n_results++;
            end
            if (i_ena && !o_busy) begin     // taken at the next rising edge
                if (cur_idx < 0) begin
                    abort_run("a start strobe was accepted while the core was busy");
                end
                idx_q.push_back(cur_idx);
                due_q.push_back(cyc + LATENCY);
                last_acc = cyc;
                started  = 1'b1;
                n_starts++;
            end
        end
    end

    initial begin
        seed       = 76521;
        cyc        = 0;
        cur_idx    = -1;
        last_acc   = 0;
        started    = 1'b0;
        n_starts   = 0;
        n_results  = 0;
        i_reset    = 1'b1;
        i_ena      = 1'b0;
        i_divident = '0;
        i_divisor  = '0;
        for (int k = 0; k < 5 * MAX_VEC; k++) begin
            vec_mem[k] = '0;
        end
        $readmemh("mant_div_vectors.txt", vec_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && vec_mem[5*num_vec] != '0) begin
            num_vec++;
        end
        if (num_vec == 0) begin
            abort_run("no vectors could be read from mant_div_vectors.txt");
        end

        repeat (10) @(posedge i_clk);
        i_reset <= 1'b0;

        for (int n = 0; n < num_vec; n++) begin
            gap = {$random(seed)} % 6;      // idle cycles before this start
            repeat (gap) @(posedge i_clk);
            start_op(n);
            if (($random(seed) & 1) != 0) begin
                pulse_during_busy();
            end
        end

        while (n_results < num_vec) begin
            @(posedge i_clk);
        end
        repeat (4) @(posedge i_clk);        // room for any stray o_valid
        if (n_starts != num_vec || n_results != num_vec) begin
            abort_run($sformatf("%0d starts and %0d results seen for %0d vectors",
                                n_starts, n_results, num_vec));
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (num_vec > 0);
        #((num_vec + 4) * 12 * 8);
        abort_run("timeout: not all results arrived in the expected time");
    end

endmodule

`default_nettype wire

// ==== mant_div_vectors.txt ====
// columns: dividend A, divisor B, expected mantissa, expected exponent correction
// (8-bit two's complement), expected sticky bit; all hex, one vector per line
10000000000000 10000000000000 10000000000000 00 0
1FFFFFFFFFFFFF 1FFFFFFFFFFFFF 10000000000000 00 0
18000000000000 0C000000000000 10000000000000 01 0
10000000000000 08000000000000 10000000000000 01 0
10000000000000 18000000000000 15555555555555 FF 1
18000000000000 10000000000000 18000000000000 00 0
1FFFFFFFFFFFFF 10000000000000 1FFFFFFFFFFFFF 00 0
10000000000000 1FFFFFFFFFFFFF 10000000000000 FF 1
10000000000001 10000000000000 10000000000001 00 0
10000000000000 10000000000001 1FFFFFFFFFFFFE FF 1
00000000000001 10000000000000 10000000000000 CC 0
10000000000000 00000000000001 10000000000000 34 0
00000000000003 00000000000001 18000000000000 01 0
00000000000001 00000000000003 15555555555555 FE 1
0000000000000A 00000000000005 10000000000000 01 0
00000000000007 0C000000000000 12AAAAAAAAAAAA CF 1
0C000000000000 00000000000003 10000000000000 32 0
15555555555555 00000000000001 15555555555555 34 0
00000000000001 1FFFFFFFFFFFFF 10000000000000 CB 1

// ==== list.f ====
mant_div_pkg.sv
divstage53.sv
mant_div_prenorm.sv
mant_div_core.sv
mant_div_postnorm.sv
mant_div53.sv
tb_mant_div53.sv

// ==== Makefile ====
# Verilator lint and simulation of the mant_div53 divider

TOP = tb_mant_div53

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

# sim fails with the exit status of the simulation binary
